//--- common/ising_pkg.sv
// Ising spin readout package
// Types shared by the lane synchronizers, sequencer, collector and registers

`include "ising_settings.svh"

package ising_pkg;

    // Spin bits of one lane
    typedef logic [`ISING_SPIN_W-1:0] spin_word_t;

    // One bit per lane
    typedef logic [`ISING_NUM_LANES-1:0] lane_mask_t;

    // Synchronizer tap, 0 selects the gated input directly
    typedef logic [$clog2(`ISING_PIPE_DEPTH+1)-1:0] tap_idx_t;

endpackage

//--- common/ising_settings.svh
// Ising spin readout settings
// Lane geometry, synchronizer depth, APB bus widths and register offsets

`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// Analog macro geometry
`define ISING_NUM_LANES  4
`define ISING_SPIN_W     16

// Stages in each lane synchronizer chain
`define ISING_PIPE_DEPTH 3

// APB slave widths
`define ISING_APB_AW     8
`define ISING_APB_DW     32

// Register byte offsets, spin lane k at SPIN0 + 4k
`define ISING_REG_CTRL   8'h00
`define ISING_REG_STATUS 8'h04
`define ISING_REG_COUNT  8'h08
`define ISING_REG_SPIN0  8'h10

`endif

//--- sim.f
+incdir+common
common/ising_pkg.sv
spin_sync/spin_synchronizer.sv
source/sample_sequencer.sv
source/spin_collector.sv
source/apb_readout_regs.sv
source/spin_readout_top.sv
test/tb_spin_readout.sv

//--- source/apb_readout_regs.sv
// APB readout registers
// Zero wait state slave holding enable and tap, issuing start and status
// acknowledge pulses, and returning status, sample count and captured spins.

`timescale 1ns/10ps
`include "ising_settings.svh"

module apb_readout_regs
    import ising_pkg::*;
(
    input  logic                                          clk_i,
    input  logic                                          arst_n_i,
    input  logic                                          psel_i,
    input  logic                                          penable_i,
    input  logic                                          pwrite_i,
    input  logic [`ISING_APB_AW-1:0]                      paddr_i,
    input  logic [`ISING_APB_DW-1:0]                      pwdata_i,
    output logic [`ISING_APB_DW-1:0]                      prdata_o,
    output logic                                          pslverr_o,
    input  logic                                          busy_i,
    input  logic                                          done_i,
    input  logic [31:0]                                   count_i,
    input  logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] spins_i,
    output logic                                          en_o,
    output tap_idx_t                                      tap_o,
    output logic                                          start_o,
    output logic                                          ack_o
);

    localparam int NUM_LANES = `ISING_NUM_LANES;
    localparam int LANE_AW   = $clog2(NUM_LANES);
    localparam int TAP_W     = $bits(tap_idx_t);

    logic                     access;
    logic                     wr_en;
    logic                     rd_en;
    logic                     hit_ctrl;
    logic                     hit_status;
    logic                     hit_count;
    logic                     hit_spin;
    logic [`ISING_APB_AW-1:0] spin_off;
    logic [LANE_AW-1:0]       spin_idx;

    logic     en_q;
    tap_idx_t tap_q;
    logic     start_q;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;
    assign rd_en  = access & ~pwrite_i;

    // Address decode
    assign hit_ctrl   = (paddr_i == `ISING_REG_CTRL);
    assign hit_status = (paddr_i == `ISING_REG_STATUS);
    assign hit_count  = (paddr_i == `ISING_REG_COUNT);
    assign spin_off   = paddr_i - `ISING_REG_SPIN0;
    assign spin_idx   = spin_off[2 +: LANE_AW];
    assign hit_spin   = (paddr_i >= `ISING_REG_SPIN0) && (spin_off < 4 * NUM_LANES) &&
                        (paddr_i[1:0] == 2'b00);

    // Error on unmapped offsets and on writes to anything but CTRL
    assign pslverr_o = access & (~(hit_ctrl | hit_status | hit_count | hit_spin) |
                                 (pwrite_i & ~hit_ctrl));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q    <= 1'b0;
            tap_q   <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_en && hit_ctrl) begin
                en_q    <= pwdata_i[0];
                tap_q   <= pwdata_i[2 +: TAP_W];
                // Start while busy is dropped here
                start_q <= pwdata_i[1] & ~busy_i;
            end
        end
    end

    // Read data, start bit always reads back 0
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o[0]         = en_q;
            prdata_o[2 +: TAP_W] = tap_q;
        end else if (hit_status) begin
            prdata_o[0] = busy_i;
            prdata_o[1] = done_i;
        end else if (hit_count) begin
            prdata_o = count_i;
        end else if (hit_spin) begin
            prdata_o[`ISING_SPIN_W-1:0] = spins_i[spin_idx];
        end
    end

    assign en_o    = en_q;
    assign tap_o   = tap_q;
    assign start_o = start_q;
    // STATUS read clears only the done value it returned
    assign ack_o   = rd_en & hit_status;

endmodule

//--- source/sample_sequencer.sv
// Sample sequencer
// Turns a start request into one lane gate per cycle, lane 0 first, so the
// analog isolation gates do not all switch together. Stalls while en is low.

`timescale 1ns/10ps
`include "ising_settings.svh"

module sample_sequencer
    import ising_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       en_i,
    input  logic       start_i,
    output lane_mask_t lane_sync_en_o,
    output logic       busy_o
);

    localparam int NUM_LANES = `ISING_NUM_LANES;

    // One-hot pointer to the next lane to open
    lane_mask_t lane_ptr;
    logic       busy_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lane_ptr <= '0;
            busy_q   <= 1'b0;
        end else if (!busy_q) begin
            if (start_i) begin
                lane_ptr <= lane_mask_t'(1);
                busy_q   <= 1'b1;
            end
        end else if (en_i) begin
            lane_ptr <= lane_ptr << 1;
            // Last lane issued this cycle
            if (lane_ptr[NUM_LANES-1]) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Gates stay shut while stalled
    assign lane_sync_en_o = lane_ptr & {NUM_LANES{en_i}};
    assign busy_o         = busy_q;

endmodule

//--- source/spin_collector.sv
// Spin collector
// Stores each lane's word on its first valid cycle, then flags the sample as
// done, raises the interrupt and counts completed samples.

`timescale 1ns/10ps
`include "ising_settings.svh"

module spin_collector
    import ising_pkg::*;
(
    input  logic                                          clk_i,
    input  logic                                          arst_n_i,
    input  logic                                          en_i,
    input  logic                                          start_i,
    input  logic                                          ack_i,
    input  lane_mask_t                                    lane_valid_i,
    input  logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] lane_spins_i,
    output logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] spins_o,
    output logic                                          done_o,
    output logic                                          irq_o,
    output logic [31:0]                                   count_o
);

    localparam int NUM_LANES = `ISING_NUM_LANES;

    lane_mask_t  captured;
    lane_mask_t  capture;
    logic        armed;
    logic        sample_end;
    logic        done_q;
    logic [31:0] count_q;

    // Only the first valid of each lane counts, and nothing moves while stalled
    assign capture    = lane_valid_i & ~captured & {NUM_LANES{en_i & armed}};
    assign sample_end = armed & (&captured);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            captured <= '0;
            armed    <= 1'b0;
        end else if (start_i) begin
            captured <= '0;
            armed    <= 1'b1;
        end else begin
            captured <= captured | capture;
            if (sample_end) begin
                armed <= 1'b0;
            end
        end
    end

    // A new completion wins over a same-cycle acknowledge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q  <= 1'b0;
            count_q <= '0;
        end else if (sample_end) begin
            done_q  <= 1'b1;
            count_q <= count_q + 32'd1;
        end else if (ack_i) begin
            done_q <= 1'b0;
        end
    end

    for (genvar k = 0; k < NUM_LANES; k++) begin : gen_word
        always_ff @(posedge clk_i) begin
            if (capture[k]) begin
                spins_o[k] <= lane_spins_i[k];
            end
        end
    end

    assign done_o  = done_q;
    assign irq_o   = done_q;
    assign count_o = count_q;

endmodule

//--- source/spin_readout_top.sv
// Spin readout top level
// APB registers, lane sequencer, one synchronizer per analog lane and the
// collector that gathers the re-timed spin words.

`timescale 1ns/10ps
`include "ising_settings.svh"

module spin_readout_top
    import ising_pkg::*;
(
    input  logic                                          clk_i,
    input  logic                                          arst_n_i,
    input  logic                                          psel_i,
    input  logic                                          penable_i,
    input  logic                                          pwrite_i,
    input  logic [`ISING_APB_AW-1:0]                      paddr_i,
    input  logic [`ISING_APB_DW-1:0]                      pwdata_i,
    output logic [`ISING_APB_DW-1:0]                      prdata_o,
    output logic                                          pslverr_o,
    input  logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] analog_spins_i,
    output logic                                          done_irq_o
);

    logic                                           sync_en;
    tap_idx_t                                       tap;
    logic                                           start_pulse;
    logic                                           ack;
    lane_mask_t                                     lane_sync_en;
    logic                                           busy;
    lane_mask_t                                     lane_valid;
    logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] lane_spins;
    logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] spins;
    logic                                           done;
    logic [31:0]                                    count;

    apb_readout_regs u_regs (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pslverr_o (pslverr_o),
        .busy_i    (busy),
        .done_i    (done),
        .count_i   (count),
        .spins_i   (spins),
        .en_o      (sync_en),
        .tap_o     (tap),
        .start_o   (start_pulse),
        .ack_o     (ack)
    );

    sample_sequencer u_sequencer (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (sync_en),
        .start_i        (start_pulse),
        .lane_sync_en_o (lane_sync_en),
        .busy_o         (busy)
    );

    for (genvar k = 0; k < `ISING_NUM_LANES; k++) begin : gen_lane
        spin_synchronizer u_sync (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .en_i      (sync_en),
            .spins_i   (analog_spins_i[k]),
            .sync_en_i (lane_sync_en[k]),
            .tap_i     (tap),
            .valid_o   (lane_valid[k]),
            .spins_o   (lane_spins[k])
        );
    end

    spin_collector u_collector (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .en_i         (sync_en),
        .start_i      (start_pulse),
        .ack_i        (ack),
        .lane_valid_i (lane_valid),
        .lane_spins_i (lane_spins),
        .spins_o      (spins),
        .done_o       (done),
        .irq_o        (done_irq_o),
        .count_o      (count)
    );

endmodule

//--- spin_sync/spin_synchronizer.sv
// Spin lane synchronizer
// Isolates one analog spin word behind an AND gate, then re-times it through
// an enable-gated shift chain. The tap picks the stage that drives the outputs.

`timescale 1ns/10ps
`include "ising_settings.svh"

module spin_synchronizer
    import ising_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       en_i,
    input  spin_word_t spins_i,
    input  logic       sync_en_i,
    input  tap_idx_t   tap_i,
    output logic       valid_o,
    output spin_word_t spins_o
);

    localparam int DEPTH = `ISING_PIPE_DEPTH;

    spin_word_t data_stage [0:DEPTH];
    logic       en_stage   [0:DEPTH];

    // Isolation gate, analog bits only pass while the lane gate is open
    assign data_stage[0] = spins_i & {`ISING_SPIN_W{sync_en_i}};
    assign en_stage[0]   = sync_en_i;

    for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
        // Marker bit follows its word down the chain
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                en_stage[i+1] <= 1'b0;
            end else if (en_i) begin
                en_stage[i+1] <= en_stage[i];
            end
        end

        // Data only moves behind a live marker
        always_ff @(posedge clk_i) begin
            if (en_i && en_stage[i]) begin
                data_stage[i+1] <= data_stage[i];
            end
        end
    end

    // Tap 0 is the gated input itself
    always_comb begin
        valid_o = en_stage[tap_i];
        spins_o = data_stage[tap_i];
    end

endmodule

//--- test/spin_readout_patterns.txt
// Columns: tap, lane 0 word, lane 1 word, lane 2 word, lane 3 word (hex)
// One sample per line
0000 1234 5678 9abc def0
0001 ffff 0000 ffff 0000
0002 a5a5 5a5a 0f0f f0f0
0003 0001 0002 0004 0008
0000 8000 4000 2000 1000
0003 cafe beef f00d 0bad
0001 3c3c c3c3 7e7e 8181
0002 0000 0000 0000 0001
0002 1111 2222 4444 8888
0001 fedc ba98 7654 3210
0003 ffff ffff ffff ffff
0000 0f1e 2d3c 4b5a 6978
0003 9999 6666 aaaa 5555
0002 0102 0304 0506 0708
0000 7fff bfff dfff efff
0001 2468 ace0 1357 9bdf

//--- test/tb_spin_readout.sv
// Spin readout testbench
// Replays tap and spin word patterns through the APB registers and checks
// readback, done and interrupt handling, sample count, stall and bus errors.

`timescale 1ns/10ps
`include "ising_settings.svh"

module tb_spin_readout;

    localparam int NUM_PATTERNS = 16;
    localparam int LINE_WORDS   = 1 + `ISING_NUM_LANES;
    localparam int MAX_POLLS    = 20;

    logic                                           clk_i;
    logic                                           arst_n_i;
    logic                                           psel_i;
    logic                                           penable_i;
    logic                                           pwrite_i;
    logic [`ISING_APB_AW-1:0]                       paddr_i;
    logic [`ISING_APB_DW-1:0]                       pwdata_i;
    logic [`ISING_APB_DW-1:0]                       prdata_o;
    logic                                           pslverr_o;
    logic [`ISING_NUM_LANES-1:0][`ISING_SPIN_W-1:0] analog_spins_i;
    logic                                           done_irq_o;

    // Per line: tap, then one spin word per lane
    logic [15:0] pattern_mem [0:NUM_PATTERNS*LINE_WORDS-1];
    integer      seed = 32'h8dd3;
    logic        irq_at_read;
    int          completed;

    spin_readout_top uut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pslverr_o      (pslverr_o),
        .analog_spins_i (analog_spins_i),
        .done_irq_o     (done_irq_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Setup cycle, then access cycle, sampled mid access
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        err = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        data        = prdata_o;
        err         = pslverr_o;
        irq_at_read = done_irq_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic read_and_compare(input string name, input logic [7:0] addr,
                                    input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value(name, data, expected);
        check_value({name, " pslverr"}, {31'b0, err}, 32'h0);
    endtask

    task automatic load_words(input int idx);
        @(posedge clk_i);
        for (int k = 0; k < `ISING_NUM_LANES; k++) begin
            analog_spins_i[k] <= pattern_mem[idx*LINE_WORDS+1+k];
        end
    endtask

    // Gates are closed here, so noise must not reach the captured words
    task automatic apply_noise();
        @(posedge clk_i);
        analog_spins_i <= {$random(seed), $random(seed)};
    endtask

    task automatic wait_for_done();
        logic [31:0] data;
        logic        err;
        int          polls;
        polls = 0;
        data  = '0;
        while (!data[1] && polls < MAX_POLLS) begin
            apb_read(`ISING_REG_STATUS, data, err);
            polls++;
        end
        if (!data[1]) begin
            $display("Sample never completed within %0d STATUS polls", MAX_POLLS);
            $display("SOME TESTS FAILED");
            $fatal(1, "Sample timeout");
        end
        // All lanes issued, so busy is already low
        check_value("STATUS", data, 32'h2);
        check_value("done_irq_o", {31'b0, irq_at_read}, 32'h1);
    endtask

    task automatic check_after_sample(input int idx);
        read_and_compare("STATUS after ack", `ISING_REG_STATUS, 32'h0);
        check_value("done_irq_o after ack", {31'b0, irq_at_read}, 32'h0);
        apply_noise();
        for (int k = 0; k < `ISING_NUM_LANES; k++) begin
            read_and_compare($sformatf("SPIN%0d", k), `ISING_REG_SPIN0 + 8'(4 * k),
                             {16'h0, pattern_mem[idx*LINE_WORDS+1+k]});
        end
        read_and_compare("COUNT", `ISING_REG_COUNT, completed);
    endtask

    initial begin
        logic [31:0] ctrl;
        logic        err;
        clk_i          = 1'b0;
        arst_n_i       = 1'b0;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        paddr_i        = '0;
        pwdata_i       = '0;
        analog_spins_i = '0;
        irq_at_read    = 1'b0;
        completed      = 0;
        $readmemh("test/spin_readout_patterns.txt", pattern_mem);
        if ($isunknown(pattern_mem[NUM_PATTERNS*LINE_WORDS-1])) begin
            $display("Pattern file is missing or holds too few lines");
            $display("SOME TESTS FAILED");
            $fatal(1, "Bad pattern file");
        end
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;

        read_and_compare("CTRL", `ISING_REG_CTRL, 32'h0);
        read_and_compare("STATUS", `ISING_REG_STATUS, 32'h0);
        read_and_compare("COUNT", `ISING_REG_COUNT, 32'h0);
        check_value("done_irq_o", {31'b0, irq_at_read}, 32'h0);

        for (int p = 0; p < NUM_PATTERNS; p++) begin
            load_words(p);
            ctrl = {28'b0, pattern_mem[p*LINE_WORDS][1:0], 2'b11};
            apb_write(`ISING_REG_CTRL, ctrl, err);
            check_value("CTRL write pslverr", {31'b0, err}, 32'h0);
            wait_for_done();
            completed++;
            check_after_sample(p);
            read_and_compare("CTRL", `ISING_REG_CTRL, ctrl & 32'hd);
        end

        // Start with en low, the sample must stall until en returns
        load_words(1);
        ctrl = {28'b0, pattern_mem[LINE_WORDS][1:0], 2'b10};
        apb_write(`ISING_REG_CTRL, ctrl, err);
        repeat (50) @(posedge clk_i);
        read_and_compare("STATUS while stalled", `ISING_REG_STATUS, 32'h1);
        apb_write(`ISING_REG_CTRL, {28'b0, pattern_mem[LINE_WORDS][1:0], 2'b01}, err);
        wait_for_done();
        completed++;
        check_after_sample(1);

        apb_read(8'h0c, ctrl, err);
        check_value("unmapped read pslverr", {31'b0, err}, 32'h1);
        apb_write(`ISING_REG_STATUS, 32'h3, err);
        check_value("STATUS write pslverr", {31'b0, err}, 32'h1);

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (NUM_PATTERNS * 200 + 2000) @(posedge clk_i);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog timeout");
    end

endmodule
